// ==== opl_pkg.sv ====
/*
 * shared widths, slot counts and types for the time-shared fm operator engine
 * every block of the bank imports this package
 */
`default_nettype none

package opl_pkg;
    localparam int NUM_CHANNELS = 9;
    localparam int NUM_OPS = 18;        // two operator slots per channel
    localparam int PHASE_WIDTH = 20;    // per-slot phase accumulator

    localparam int FNUM_WIDTH = 10;
    localparam int BLOCK_WIDTH = 3;
    localparam int FB_WIDTH = 3;
    localparam int CONN_SEL_WIDTH = 3;  // one bit per 4-op channel pair
    localparam int OP_NUM_WIDTH = 5;
    localparam int ANGLE_WIDTH = 10;
    localparam int OP_OUT_WIDTH = 13;

    typedef logic [FNUM_WIDTH-1:0] fnum_t;
    typedef logic [BLOCK_WIDTH-1:0] block_t;
    typedef logic [FB_WIDTH-1:0] fb_t;
    typedef logic [CONN_SEL_WIDTH-1:0] conn_sel_t;
    typedef logic [OP_NUM_WIDTH-1:0] op_num_t;
    typedef logic [ANGLE_WIDTH-1:0] angle_t;

    // signed operator sample
    typedef logic signed [OP_OUT_WIDTH-1:0] op_out_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_SWEEP
    } seq_state_t;
endpackage

`default_nettype wire

// ==== op_slot_sequencer.sv ====
/*
 * sweep sequencer, a sample_clk_en pulse starts one pass over all slots
 * presents one slot number per clock with slot_valid high during the pass
 */
`default_nettype none

module op_slot_sequencer (
    input wire clk,
    input wire reset,
    input wire sample_clk_en,
    output opl_pkg::op_num_t slot,
    output logic slot_valid
);
    import opl_pkg::*;

    seq_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEQ_IDLE;
            slot <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    slot <= '0;
                    if (sample_clk_en) begin
                        state <= SEQ_SWEEP;
                    end
                end
                SEQ_SWEEP: begin
                    // pulses arriving mid-sweep are simply not looked at
                    if (slot == op_num_t'(NUM_OPS - 1)) begin
                        state <= SEQ_IDLE;
                        slot <= '0;
                    end else begin
                        slot <= slot + 1'b1;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    assign slot_valid = (state == SEQ_SWEEP);
endmodule

`default_nettype wire

// ==== op_param_router.sv ====
/*
 * routes channel parameters to the active operator slot
 * follows the opl3 channel-to-operator map and the 2-op / 4-op connection rules
 */
`default_nettype none

module op_param_router (
    input wire opl_pkg::op_num_t slot,
    input wire opl_pkg::conn_sel_t connection_sel,
    input wire opl_pkg::fnum_t fnum [opl_pkg::NUM_CHANNELS],
    input wire opl_pkg::block_t block [opl_pkg::NUM_CHANNELS],
    input wire kon [opl_pkg::NUM_CHANNELS],
    input wire opl_pkg::fb_t fb [opl_pkg::NUM_CHANNELS],
    input wire cnt [opl_pkg::NUM_CHANNELS],
    output opl_pkg::fnum_t op_fnum,
    output opl_pkg::block_t op_block,
    output logic op_kon,
    output opl_pkg::fb_t op_fb,
    output logic use_feedback,
    output logic use_modulation,
    output opl_pkg::op_num_t mod_slot
);
    import opl_pkg::*;

    localparam int CH_WIDTH = $clog2(NUM_CHANNELS);

    logic [1:0] grp;            // groups of six slots, three channels each
    op_num_t pos;               // slot within its group
    logic second;               // second operator of its channel
    logic [1:0] k;
    logic [CH_WIDTH-1:0] ch;
    logic chain;                // slot belongs to a joined 4-op pair

    always_comb begin
        if (slot < op_num_t'(6)) begin
            grp = 2'd0;
            pos = slot;
        end else if (slot < op_num_t'(12)) begin
            grp = 2'd1;
            pos = slot - op_num_t'(6);
        end else begin
            grp = 2'd2;
            pos = slot - op_num_t'(12);
        end

        second = (pos >= op_num_t'(3));
        k = second ? 2'(pos - op_num_t'(3)) : 2'(pos);
        ch = CH_WIDTH'(3 * grp + k);

        // only slots 6-11 can join with channels 0-2
        chain = (grp == 2'd1) && connection_sel[k];

        // plain 2-op channel
        op_fnum = fnum[ch];
        op_block = block[ch];
        op_kon = kon[ch];
        op_fb = second ? fb_t'(0) : fb[ch];
        use_feedback = !second;
        use_modulation = second && !cnt[ch];

        if (chain) begin
            // whole chain runs at channel k's pitch, ch is channel 3+k here
            op_fnum = fnum[k];
            op_block = block[k];
            op_kon = kon[k];
            op_fb = '0;
            use_feedback = 1'b0;
            if (second) begin
                use_modulation = !(cnt[k] && cnt[ch]);
            end else begin
                use_modulation = !(!cnt[k] && cnt[ch]);
            end
        end
    end

    // wraps for slots 0-2, which are never modulated
    assign mod_slot = slot - op_num_t'(3);
endmodule

`default_nettype wire

// ==== op_phase_wave.sv ====
/*
 * shared operator datapath, two register stages per slot
 * stage 1 advances the slot phase and forms the angle, stage 2 the triangle wave
 */
`default_nettype none

module op_phase_wave #(
    parameter int PHASE_FRAC_BITS = 10
) (
    input wire clk,
    input wire reset,
    input wire slot_valid,
    input wire opl_pkg::op_num_t slot,
    input wire opl_pkg::fnum_t op_fnum,
    input wire opl_pkg::block_t op_block,
    input wire op_kon,
    input wire opl_pkg::fb_t op_fb,
    input wire use_feedback,
    input wire use_modulation,
    input wire opl_pkg::op_out_t mod_out,
    input wire opl_pkg::op_out_t fb_out,
    output logic wave_valid,
    output opl_pkg::op_num_t wave_slot,
    output opl_pkg::op_out_t wave_out
);
    import opl_pkg::*;

    // fewer fraction bits means a coarser step, increment scaled up to match
    localparam int INC_SHIFT = PHASE_WIDTH - ANGLE_WIDTH - PHASE_FRAC_BITS;

    logic [PHASE_WIDTH-1:0] phase [NUM_OPS];
    logic [PHASE_WIDTH-1:0] phase_inc;
    logic [PHASE_WIDTH-1:0] phase_next;
    logic signed [ANGLE_WIDTH-1:0] fb_low;
    angle_t mod_term;
    angle_t fb_term;
    angle_t angle;

    logic s1_valid;
    op_num_t s1_slot;
    logic s1_kon;
    angle_t s1_angle;
    op_out_t angle_ext;
    op_out_t tri_val;

    always_comb begin
        phase_inc = (PHASE_WIDTH'(op_fnum) << op_block) << INC_SHIFT;
        phase_next = op_kon ? phase[slot] + phase_inc : '0;   // key-off restarts the phase

        mod_term = use_modulation ? mod_out[ANGLE_WIDTH-1:0] : '0;

        fb_low = fb_out[ANGLE_WIDTH-1:0];
        if (use_feedback && op_fb != '0) begin
            fb_term = fb_low >>> (4'd9 - {1'b0, op_fb});
        end else begin
            fb_term = '0;
        end

        angle = phase_next[PHASE_WIDTH-1 -: ANGLE_WIDTH] + mod_term + fb_term;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            for (int i = 0; i < NUM_OPS; i++) begin
                phase[i] <= '0;
            end
        end else begin
            s1_valid <= slot_valid;
            if (slot_valid) begin
                phase[slot] <= phase_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_slot <= slot;
        s1_kon <= op_kon;
        s1_angle <= angle;
    end

    // rising ramp over the first half, falling over the second
    always_comb begin
        angle_ext = op_out_t'(s1_angle);
        if (s1_angle[ANGLE_WIDTH-1]) begin
            tri_val = op_out_t'(767) - angle_ext;
        end else begin
            tri_val = angle_ext - op_out_t'(256);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wave_valid <= 1'b0;
        end else begin
            wave_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        wave_slot <= s1_slot;
        wave_out <= s1_kon ? (tri_val <<< 2) : '0;
    end
endmodule

`default_nettype wire

// ==== op_output_store.sv ====
/*
 * latest output of every slot, written as results leave the operator
 * serves modulation and feedback reads and flags the end of a sweep
 */
`default_nettype none

module op_output_store (
    input wire clk,
    input wire reset,
    input wire wave_valid,
    input wire opl_pkg::op_num_t wave_slot,
    input wire opl_pkg::op_out_t wave_out,
    input wire opl_pkg::op_num_t mod_slot,
    input wire opl_pkg::op_num_t slot,
    output opl_pkg::op_out_t mod_out,
    output opl_pkg::op_out_t fb_out,
    output opl_pkg::op_out_t operator_out [opl_pkg::NUM_OPS],
    output logic ops_done
);
    import opl_pkg::*;

    logic wave_valid_d;

    // operator_out doubles as the slot memory
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                operator_out[i] <= '0;
            end
            wave_valid_d <= 1'b0;
            ops_done <= 1'b0;
        end else begin
            if (wave_valid) begin
                operator_out[wave_slot] <= wave_out;
            end
            wave_valid_d <= wave_valid;
            ops_done <= wave_valid_d && !wave_valid;   // one cycle after the last write
        end
    end

    // modulator was written three slots ago in this same sweep
    assign mod_out = (mod_slot < op_num_t'(NUM_OPS)) ? operator_out[mod_slot] : '0;

    // own value from the previous sweep, not yet overwritten
    assign fb_out = operator_out[slot];
endmodule

`default_nettype wire

// ==== opl_operators.sv ====
/*
 * top of the operator engine for one 18-slot voice bank
 * one sweep per sample_clk_en, all slot outputs and ops_done exposed
 */
`default_nettype none

module opl_operators #(
    parameter int PHASE_FRAC_BITS = 10
) (
    input wire clk,
    input wire reset,
    input wire sample_clk_en,
    input wire opl_pkg::conn_sel_t connection_sel,
    input wire opl_pkg::fnum_t fnum [opl_pkg::NUM_CHANNELS],
    input wire opl_pkg::block_t block [opl_pkg::NUM_CHANNELS],
    input wire kon [opl_pkg::NUM_CHANNELS],
    input wire opl_pkg::fb_t fb [opl_pkg::NUM_CHANNELS],
    input wire cnt [opl_pkg::NUM_CHANNELS],
    output opl_pkg::op_out_t operator_out [opl_pkg::NUM_OPS],
    output logic ops_done
);
    import opl_pkg::*;

    op_num_t slot;
    logic slot_valid;

    fnum_t op_fnum;
    block_t op_block;
    logic op_kon;
    fb_t op_fb;
    logic use_feedback;
    logic use_modulation;
    op_num_t mod_slot;

    op_out_t mod_out;
    op_out_t fb_out;

    logic wave_valid;
    op_num_t wave_slot;
    op_out_t wave_out;

    op_slot_sequencer i_sequencer (
        .clk,
        .reset,
        .sample_clk_en,
        .slot,
        .slot_valid
    );

    op_param_router i_router (
        .slot,
        .connection_sel,
        .fnum,
        .block,
        .kon,
        .fb,
        .cnt,
        .op_fnum,
        .op_block,
        .op_kon,
        .op_fb,
        .use_feedback,
        .use_modulation,
        .mod_slot
    );

    op_phase_wave #(
        .PHASE_FRAC_BITS(PHASE_FRAC_BITS)
    ) i_operator (
        .clk,
        .reset,
        .slot_valid,
        .slot,
        .op_fnum,
        .op_block,
        .op_kon,
        .op_fb,
        .use_feedback,
        .use_modulation,
        .mod_out,
        .fb_out,
        .wave_valid,
        .wave_slot,
        .wave_out
    );

    op_output_store i_store (
        .clk,
        .reset,
        .wave_valid,
        .wave_slot,
        .wave_out,
        .mod_slot,
        .slot,
        .mod_out,
        .fb_out,
        .operator_out,
        .ops_done
    );
endmodule

`default_nettype wire

// ==== opl_operators_chk.sv ====
/*
 * assertions on sweep length and ops_done timing of the operator engine
 * bound into the top level where the sequencer and store signals meet
 */
`default_nettype none

module opl_operators_chk (
    input wire clk,
    input wire reset,
    input wire slot_valid,
    input wire ops_done
);
    logic [4:0] valid_len;  // cycles of the running sweep
    logic done_seen;        // ops_done already given in this sweep

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_len <= '0;
        end else if (slot_valid) begin
            valid_len <= valid_len + 5'd1;
        end else begin
            valid_len <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done_seen <= 1'b0;
        end else if (slot_valid && valid_len == 5'd0) begin
            done_seen <= 1'b0;      // new sweep
        end else if (ops_done) begin
            done_seen <= 1'b1;
        end
    end

    sweep_not_too_long: assert property (@(posedge clk) disable iff (reset)
        slot_valid |-> valid_len < 5'd18)
        else $error("slot_valid stayed high past 18 cycles");

    sweep_length: assert property (@(posedge clk) disable iff (reset)
        $fell(slot_valid) |-> valid_len == 5'd18)
        else $error("slot_valid was not high for exactly 18 cycles");

    done_single: assert property (@(posedge clk) disable iff (reset)
        ops_done |-> !done_seen)
        else $error("ops_done pulsed more than once in one sweep");

    // slot_valid first seen one edge after the start edge
    done_timing: assert property (@(posedge clk) disable iff (reset)
        ops_done |-> $past(slot_valid, 21) && !$past(slot_valid, 22))
        else $error("ops_done did not come 21 edges after the sweep start");
endmodule

bind opl_operators opl_operators_chk i_chk (
    .clk(clk),
    .reset(reset),
    .slot_valid(slot_valid),
    .ops_done(ops_done)
);

`default_nettype wire

// ==== tb_opl_operators.sv ====
/*
 * directed testbench for the 18-slot operator engine
 * each test sets channel inputs, runs sweeps and compares all outputs with a sweep model
 */
`default_nettype none

module tb_opl_operators;
    import opl_pkg::*;

    localparam int FRAC_BITS = 10;
    localparam int NUM_SWEEPS = 14;
    localparam int CYCLE_LIMIT = 40 * NUM_SWEEPS + 100;

    logic clk;
    logic reset;
    logic sample_clk_en;
    conn_sel_t connection_sel;
    fnum_t fnum [NUM_CHANNELS];
    block_t block [NUM_CHANNELS];
    logic kon [NUM_CHANNELS];
    fb_t fb [NUM_CHANNELS];
    logic cnt [NUM_CHANNELS];
    op_out_t operator_out [NUM_OPS];
    logic ops_done;

    logic [PHASE_WIDTH-1:0] model_phase [NUM_OPS];
    op_out_t model_out [NUM_OPS];
    int seed = 71;
    int done_count = 0;
    int cycles = 0;
    int checks = 0;
    int errors = 0;

    opl_operators #(
        .PHASE_FRAC_BITS(FRAC_BITS)
    ) i_opl_operators (
        .clk,
        .reset,
        .sample_clk_en,
        .connection_sel,
        .fnum,
        .block,
        .kon,
        .fb,
        .cnt,
        .operator_out,
        .ops_done
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (ops_done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_out(input string name, input int idx, input op_out_t expected,
                             input op_out_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s slot %0d expected %0d actual %0d", name, idx, expected, actual);
        end
    endtask

    task automatic check_done(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("MISMATCH %s ops_done pulses expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // one sweep of the bank in slot order, modulators already updated
    task automatic model_sweep();
        int k;
        int ch;
        bit second;
        bit use_fb;
        bit use_mod;
        fnum_t f;
        block_t b;
        logic on;
        fb_t fbl;
        logic [PHASE_WIDTH-1:0] inc;
        angle_t ang;
        logic signed [ANGLE_WIDTH-1:0] fb_low;
        for (int s = 0; s < NUM_OPS; s++) begin
            k = (s % 6) % 3;
            ch = (s / 6) * 3 + k;
            second = (s % 6) >= 3;
            f = fnum[ch];
            b = block[ch];
            on = kon[ch];
            fbl = fb[ch];
            use_fb = !second;
            use_mod = second && !cnt[ch];
            if (s >= 6 && s < 12 && connection_sel[k]) begin
                f = fnum[k];    // chain runs at the lower channel's pitch
                b = block[k];
                on = kon[k];
                use_fb = 1'b0;
                use_mod = second ? !(cnt[k] && cnt[ch]) : !(!cnt[k] && cnt[ch]);
            end
            inc = (PHASE_WIDTH'(f) << b) << (PHASE_WIDTH - ANGLE_WIDTH - FRAC_BITS);
            model_phase[s] = on ? model_phase[s] + inc : '0;
            ang = model_phase[s][PHASE_WIDTH-1 -: ANGLE_WIDTH];
            if (use_mod) begin
                ang = ang + model_out[s - 3][ANGLE_WIDTH-1:0];
            end
            if (use_fb && fbl != '0) begin
                fb_low = model_out[s][ANGLE_WIDTH-1:0];   // last sweep's own output
                ang = ang + angle_t'(fb_low >>> (9 - int'(fbl)));
            end
            if (!on) begin
                model_out[s] = '0;
            end else if (ang < 10'd512) begin
                model_out[s] = op_out_t'((int'(ang) - 256) * 4);
            end else begin
                model_out[s] = op_out_t'((767 - int'(ang)) * 4);
            end
        end
    endtask

    // entered and left on a falling edge
    task automatic run_sweep(input string name, input bit extra_pulse);
        int start_count;
        start_count = done_count;
        sample_clk_en = 1'b1;
        @(negedge clk);
        sample_clk_en = 1'b0;
        if (extra_pulse) begin
            repeat (5) @(negedge clk);
            sample_clk_en = 1'b1;   // lands mid-sweep
            @(negedge clk);
            sample_clk_en = 1'b0;
        end
        while (done_count == start_count) begin
            @(negedge clk);
        end
        // after a mid-sweep pulse, long enough for a second sweep to show up
        repeat (extra_pulse ? 24 : 4) @(negedge clk);
        check_done(name, 1, done_count - start_count);
        model_sweep();
        for (int s = 0; s < NUM_OPS; s++) begin
            check_out(name, s, model_out[s], operator_out[s]);
        end
    endtask

    task automatic test_key_off();
        run_sweep("key_off", 1'b0);
    endtask

    task automatic test_fm_2op();
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            kon[c] = 1'b1;
            fnum[c] = fnum_t'($random(seed));
            block[c] = block_t'(c % 8);
        end
        for (int i = 0; i < 3; i++) begin
            run_sweep($sformatf("fm_2op_%0d", i), 1'b0);
        end
    endtask

    task automatic test_additive_feedback();
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            cnt[c] = (c % 2 == 0);
            fb[c] = fb_t'(c % 7 + 1);
        end
        for (int i = 0; i < 3; i++) begin
            run_sweep($sformatf("add_fb_%0d", i), 1'b0);
        end
    endtask

    task automatic test_chain_4op();
        logic [1:0] combo;
        connection_sel = 3'b111;
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 3; k++) begin
                combo = 2'((i + k) % 4);  // each pair sees all four cnt pairs
                cnt[k] = combo[1];
                cnt[3 + k] = combo[0];
            end
            run_sweep($sformatf("chain_4op_%0d", i), 1'b0);
        end
        connection_sel = '0;
    endtask

    task automatic test_pulse_and_restart();
        run_sweep("ignored_pulse", 1'b1);
        kon[2] = 1'b0;
        run_sweep("kon_low", 1'b0);
        check_out("kon_low", 2, '0, operator_out[2]);
        check_out("kon_low", 5, '0, operator_out[5]);
        kon[2] = 1'b1;
        run_sweep("kon_restart", 1'b0);
    endtask

    initial begin
        reset = 1'b1;
        sample_clk_en = 1'b0;
        connection_sel = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            fnum[c] = '0;
            block[c] = '0;
            kon[c] = 1'b0;
            fb[c] = '0;
            cnt[c] = 1'b0;
        end
        for (int s = 0; s < NUM_OPS; s++) begin
            model_phase[s] = '0;
            model_out[s] = '0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        test_key_off();
        test_fm_2op();
        test_additive_feedback();
        test_chain_4op();
        test_pulse_and_restart();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== opl_operators.f ====
opl_pkg.sv
op_slot_sequencer.sv
op_param_router.sv
op_phase_wave.sv
op_output_store.sv
opl_operators.sv
opl_operators_chk.sv
tb_opl_operators.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the operator engine testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_opl_operators -f opl_operators.f -o sim_opl_operators
./obj_dir/sim_opl_operators | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
